//--- rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_RESET_PC   32'h8000_0000  // first fetch address
`define RV_XLEN       32
`define RV_NREGS      32

// instruction length in bytes, pc step for sequential flow
`define RV_ILEN       4

// major opcodes, inst[6:0]
`define RV_OP_LOAD    7'b000_0011
`define RV_OP_STORE   7'b010_0011
`define RV_OP_OP      7'b011_0011
`define RV_OP_OP_IMM  7'b001_0011
`define RV_OP_LUI     7'b011_0111
`define RV_OP_AUIPC   7'b001_0111
`define RV_OP_BRANCH  7'b110_0011
`define RV_OP_JAL     7'b110_1111
`define RV_OP_JALR    7'b110_0111
`define RV_OP_SYSTEM  7'b111_0011  // only ebreak is kept

`endif

//--- rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;  // data, addresses, instructions
  typedef logic [4:0]          reg_addr_t;
  typedef logic [3:0]          wmask_t;   // one bit per byte lane
  typedef logic [2:0]          funct3_t;
  typedef logic [6:0]          opcode_t;

  // one instruction at a time, four phases each
  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXECUTE,
    WRITEBACK,
    HALT
  } seq_state_t;

endpackage

`default_nettype wire

//--- stage_ifs.sv
`default_nettype none

// decoded instruction, held steady while the instruction is in flight
interface dec_exe_if
  import rv_pkg::*;
();
  word_t     pc;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     imm;
  funct3_t   funct3;
  reg_addr_t rd;
  logic      alt;        // sub for op, sra for shift right
  logic      is_op;
  logic      is_op_imm;
  logic      is_lui;
  logic      is_auipc;
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  logic      is_load;
  logic      is_store;
  logic      reg_write;

  modport driver (
    output pc, rs1_data, rs2_data, imm, funct3, rd, alt,
    output is_op, is_op_imm, is_lui, is_auipc, is_branch,
    output is_jal, is_jalr, is_load, is_store, reg_write
  );

  modport reader (
    input pc, rs1_data, rs2_data, imm, funct3, rd, alt,
    input is_op, is_op_imm, is_lui, is_auipc, is_branch,
    input is_jal, is_jalr, is_load, is_store, reg_write
  );
endinterface

// execute results, captured at the end of EXECUTE
interface exe_wb_if
  import rv_pkg::*;
();
  word_t alu_result;  // also the data address
  word_t target;      // branch, jump or auipc sum
  word_t link;        // pc + 4
  logic  taken;

  modport driver (output alu_result, target, link, taken);
  modport reader (input  alu_result, target, link, taken);
endinterface

`default_nettype wire

//--- fetch_stage.sv
`default_nettype none

`include "rv_defines.svh"

module fetch_stage
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  word_t      next_pc,
  input  logic       halt_req,
  input  word_t      imem_rdata,
  output logic       imem_req,
  output word_t      imem_addr,
  output word_t      pc,
  output word_t      inst,
  output seq_state_t state,
  output logic       halted
);

  logic started;  // low for the first cycle out of reset

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= FETCH;
      started <= 1'b0;
      pc      <= `RV_RESET_PC;
    end else begin
      started <= 1'b1;
      case (state)
        FETCH: begin
          if (started) begin
            state <= DECODE;
          end
        end
        DECODE:    state <= EXECUTE;
        EXECUTE:   state <= WRITEBACK;
        WRITEBACK: begin
          state <= halt_req ? HALT : FETCH;  // ebreak parks the sequencer
          pc    <= next_pc;
        end
        default:   state <= HALT;
      endcase
    end
  end

  // memory answers one cycle after the request
  always_ff @(posedge clk) begin
    if (state == DECODE) begin
      inst <= imem_rdata;
    end
  end

  assign imem_req  = started && (state == FETCH);
  assign imem_addr = pc;
  assign halted    = (state == HALT);

  // a fetch is followed by three quiet cycles
  a_fetch_cadence: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req |-> (state == FETCH) ##1 (!imem_req) [*3]);

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

`include "rv_defines.svh"

module reg_file
  import rv_pkg::*;
(
  input  logic      clk,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  input  word_t     rd_data,
  input  logic      rd_we,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [0:`RV_NREGS-1];

  always_ff @(posedge clk) begin
    if (rd_we && (rd_addr != '0)) begin  // x0 stays zero
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- decode_stage.sv
`default_nettype none

`include "rv_defines.svh"

module decode_stage
  import rv_pkg::*;
(
  input  word_t          inst,
  output reg_addr_t      rs1_addr,
  output reg_addr_t      rs2_addr,
  output logic           halt_req,
  input  word_t          rs1_data,
  input  word_t          rs2_data,
  input  word_t          pc,
  dec_exe_if.driver      dx
);

  opcode_t opcode;
  funct3_t funct3;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_u;
  word_t   imm_j;

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  // sign bit is always inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign dx.pc       = pc;
  assign dx.rs1_data = rs1_data;
  assign dx.rs2_data = rs2_data;
  assign dx.funct3   = funct3;
  assign dx.rd       = inst[11:7];
  // inst[30] only means something for op and shift right
  assign dx.alt      = inst[30] && ((opcode == `RV_OP_OP)
                    || ((opcode == `RV_OP_OP_IMM) && (funct3 == 3'b101)));

  assign halt_req = (opcode == `RV_OP_SYSTEM) && (funct3 == 3'b000);

  always_comb begin
    dx.is_op     = 1'b0;
    dx.is_op_imm = 1'b0;
    dx.is_lui    = 1'b0;
    dx.is_auipc  = 1'b0;
    dx.is_branch = 1'b0;
    dx.is_jal    = 1'b0;
    dx.is_jalr   = 1'b0;
    dx.is_load   = 1'b0;
    dx.is_store  = 1'b0;
    dx.imm       = imm_i;  // op_imm, load, jalr
    case (opcode)
      `RV_OP_OP:     dx.is_op = 1'b1;
      `RV_OP_OP_IMM: begin
        dx.is_op_imm = 1'b1;
        if ((funct3 == 3'b001) || (funct3 == 3'b101)) begin
          dx.imm = {27'd0, inst[24:20]};  // shamt only
        end
      end
      `RV_OP_LUI: begin
        dx.is_lui = 1'b1;
        dx.imm    = imm_u;
      end
      `RV_OP_AUIPC: begin
        dx.is_auipc = 1'b1;
        dx.imm      = imm_u;
      end
      `RV_OP_BRANCH: begin
        dx.is_branch = 1'b1;
        dx.imm       = imm_b;
      end
      `RV_OP_JAL: begin
        dx.is_jal = 1'b1;
        dx.imm    = imm_j;
      end
      `RV_OP_JALR:   dx.is_jalr = 1'b1;
      `RV_OP_LOAD:   dx.is_load = 1'b1;
      `RV_OP_STORE: begin
        dx.is_store = 1'b1;
        dx.imm      = imm_s;
      end
      default: ;  // system and unknown opcodes raise no class
    endcase

    dx.reg_write = dx.is_op || dx.is_op_imm || dx.is_lui || dx.is_auipc
                || dx.is_jal || dx.is_jalr || dx.is_load;

    a_class_onehot: assert ($onehot0({dx.is_op, dx.is_op_imm, dx.is_lui, dx.is_auipc,
                                      dx.is_branch, dx.is_jal, dx.is_jalr,
                                      dx.is_load, dx.is_store}))
      else $error("decode: more than one instruction class active");
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
`default_nettype none

`include "rv_defines.svh"

module execute_stage
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  seq_state_t state,
  dec_exe_if.reader  dx,
  exe_wb_if.driver   xw,
  output logic       dmem_re,
  output logic       dmem_we,
  output word_t      dmem_addr,
  output word_t      dmem_wdata,
  output wmask_t     dmem_wmask
);

  word_t      op_a;
  word_t      op_b;
  word_t      alu;
  word_t      tgt_base;
  word_t      tgt_sum;
  funct3_t    alu_f3;
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;
  logic       cond;

  assign op_a   = dx.rs1_data;
  assign op_b   = (dx.is_op || dx.is_branch) ? dx.rs2_data : dx.imm;
  assign alu_f3 = (dx.is_op || dx.is_op_imm) ? dx.funct3 : 3'b000;  // address add otherwise
  assign shamt  = op_b[4:0];

  // shared by slt/sltu and the branches
  assign eq  = (op_a == op_b);
  assign lt  = ($signed(op_a) < $signed(op_b));
  assign ltu = (op_a < op_b);

  always_comb begin
    case (alu_f3)
      3'b000:  alu = dx.alt ? (op_a - op_b) : (op_a + op_b);
      3'b001:  alu = op_a << shamt;
      3'b010:  alu = word_t'(lt);
      3'b011:  alu = word_t'(ltu);
      3'b100:  alu = op_a ^ op_b;
      3'b101: begin
        if (dx.alt) begin
          alu = $signed(op_a) >>> shamt;
        end else begin
          alu = op_a >> shamt;
        end
      end
      3'b110:  alu = op_a | op_b;
      default: alu = op_a & op_b;
    endcase
  end

  always_comb begin
    case (dx.funct3)
      3'b000:  cond = eq;    // beq
      3'b001:  cond = !eq;   // bne
      3'b100:  cond = lt;    // blt
      3'b101:  cond = !lt;   // bge
      3'b110:  cond = ltu;   // bltu
      3'b111:  cond = !ltu;  // bgeu
      default: cond = 1'b0;
    endcase
  end

  // jalr target drops bit 0
  assign tgt_base = dx.is_jalr ? dx.rs1_data : dx.pc;
  assign tgt_sum  = tgt_base + dx.imm;

  always_ff @(posedge clk) begin
    if (state == EXECUTE) begin
      xw.alu_result <= alu;
      xw.target     <= tgt_sum & ~word_t'(dx.is_jalr);
      xw.link       <= dx.pc + word_t'(`RV_ILEN);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      xw.taken <= 1'b0;
    end else if (state == EXECUTE) begin
      xw.taken <= dx.is_branch && cond;
    end
  end

  // request goes out in EXECUTE, response lands in WRITEBACK
  assign dmem_re   = (state == EXECUTE) && dx.is_load;
  assign dmem_we   = (state == EXECUTE) && dx.is_store;
  assign dmem_addr = alu;

  always_comb begin
    case (dx.funct3[1:0])
      2'b00: begin  // sb, byte on every lane
        dmem_wdata = {4{dx.rs2_data[7:0]}};
        dmem_wmask = 4'b0001 << alu[1:0];
      end
      2'b01: begin  // sh
        dmem_wdata = {2{dx.rs2_data[15:0]}};
        dmem_wmask = alu[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = dx.rs2_data;
        dmem_wmask = 4'b1111;
      end
    endcase
  end

  // class flags come from decode as one-hot
  a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_re && dmem_we));

endmodule

`default_nettype wire

//--- mem_wb_stage.sv
`default_nettype none

module mem_wb_stage
  import rv_pkg::*;
(
  dec_exe_if.reader  dx,
  exe_wb_if.reader   xw,
  input  word_t      dmem_rdata,
  output logic       rd_we,
  output word_t      rd_data,
  output word_t      next_pc,
  input  seq_state_t state
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  word_t       load_data;

  // lane picked by the low address bits
  assign ld_byte = dmem_rdata[8*xw.alu_result[1:0] +: 8];
  assign ld_half = xw.alu_result[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

  always_comb begin
    case (dx.funct3)
      3'b000:  load_data = {{24{ld_byte[7]}}, ld_byte};   // lb
      3'b001:  load_data = {{16{ld_half[15]}}, ld_half};  // lh
      3'b100:  load_data = {24'd0, ld_byte};              // lbu
      3'b101:  load_data = {16'd0, ld_half};              // lhu
      default: load_data = dmem_rdata;                    // lw
    endcase
  end

  assign rd_data = dx.is_load                 ? load_data :
                   (dx.is_jal || dx.is_jalr)  ? xw.link :
                   dx.is_lui                  ? dx.imm :
                   dx.is_auipc                ? xw.target :
                                                xw.alu_result;

  // written at the end of WRITEBACK, same edge as the pc
  assign rd_we = (state == WRITEBACK) && dx.reg_write;

  assign next_pc = (dx.is_jal || dx.is_jalr || xw.taken) ? xw.target : xw.link;

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none

module rv_core
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  output logic   imem_req,
  output word_t  imem_addr,
  input  word_t  imem_rdata,
  output logic   dmem_re,
  output logic   dmem_we,
  output word_t  dmem_addr,
  output word_t  dmem_wdata,
  output wmask_t dmem_wmask,
  input  word_t  dmem_rdata,
  output logic   halted
);

  word_t      pc;
  word_t      inst;
  word_t      next_pc;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      rd_data;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  logic       rd_we;
  logic       halt_req;
  seq_state_t state;

  dec_exe_if dx_if ();
  exe_wb_if  xw_if ();

  fetch_stage fetch_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .next_pc    (next_pc),
    .halt_req   (halt_req),
    .imem_rdata (imem_rdata),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .pc         (pc),
    .inst       (inst),
    .state      (state),
    .halted     (halted)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (dx_if.rd),
    .rd_data  (rd_data),
    .rd_we    (rd_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  decode_stage decode_inst (
    .inst     (inst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .halt_req (halt_req),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .dx       (dx_if.driver)
  );

  execute_stage execute_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .dx         (dx_if.reader),
    .xw         (xw_if.driver),
    .dmem_re    (dmem_re),
    .dmem_we    (dmem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask)
  );

  mem_wb_stage mem_wb_inst (
    .dx         (dx_if.reader),
    .xw         (xw_if.reader),
    .dmem_rdata (dmem_rdata),
    .rd_we      (rd_we),
    .rd_data    (rd_data),
    .next_pc    (next_pc),
    .state      (state)
  );

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`default_nettype none

`include "rv_defines.svh"

module tb_rv_core
  import rv_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    clk_period   = 10;
  localparam int    reset_cycles = 16;
  localparam word_t st_base      = 32'h8000_0400;  // one result word per store
  localparam word_t rand_addr    = 32'h8000_0380;  // source word for the loads
  localparam word_t poison       = 32'hbad0_0bad;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   imem_req;
  word_t  imem_addr;
  word_t  imem_rdata;
  logic   dmem_re;
  logic   dmem_we;
  word_t  dmem_addr;
  word_t  dmem_wdata;
  wmask_t dmem_wmask;
  word_t  dmem_rdata;
  logic   halted;

  word_t  mem [0:511];     // 2 KiB from the reset pc
  word_t  regs_m [0:31];   // register values the program should produce
  word_t  exp_fetch [$];
  word_t  exp_addr [$];
  word_t  exp_data [$];
  wmask_t exp_mask [$];
  int     prog_idx = 0;
  int     st_off = 0;
  int     since_fetch = 0;
  integer seed = 32'hadd7;
  word_t  rand_word;
  logic   prog_ready = 1'b0;
  logic   fetch_seen = 1'b0;
  logic   halted_seen = 1'b0;
  logic   imem_pend = 1'b0;
  word_t  imem_pend_addr;
  logic   dmem_pend = 1'b0;
  word_t  dmem_pend_addr;

  rv_core rv_core_inst (.*);

  always #(clk_period / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  function automatic logic [8:0] mem_index(word_t addr);
    word_t offset;
    offset = addr - `RV_RESET_PC;
    return offset[10:2];
  endfunction

  function automatic word_t cur_pc();
    return `RV_RESET_PC + word_t'(4 * prog_idx);
  endfunction

  function automatic word_t r_type(logic [6:0] f7, int rs2, int rs1, int f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), `RV_OP_OP};
  endfunction

  function automatic word_t i_type(word_t imm, int rs1, int f3, int rd, opcode_t op);
    return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic word_t s_type(word_t imm, int rs2, int rs1, int f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic word_t b_type(word_t imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3),
            imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic word_t u_type(word_t imm20, int rd, opcode_t op);
    return {imm20[19:0], 5'(rd), op};
  endfunction

  function automatic word_t j_type(word_t imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), `RV_OP_JAL};
  endfunction

  // rv32i integer semantics, funct3 plus the bit 30 variant
  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? (a - b) : (a + b);
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic put(word_t inst);  // executed, so its fetch is expected
    exp_fetch.push_back(cur_pc());
    mem[prog_idx] = inst;
    prog_idx++;
  endtask

  task automatic put_skipped(word_t inst);
    mem[prog_idx] = inst;
    prog_idx++;
  endtask

  task automatic expect_store(word_t addr, word_t data, wmask_t mask);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_mask.push_back(mask);
  endtask

  task automatic load_imm(int rd, word_t value);
    word_t upper;
    upper = (value + 32'h800) >> 12;  // addi sign-extends the low part
    put(u_type(upper, rd, `RV_OP_LUI));
    put(i_type(value, rd, 0, rd, `RV_OP_OP_IMM));
    regs_m[rd] = value;
  endtask

  task automatic store_word(int rs);
    put(s_type(word_t'(st_off), rs, 3, 2));
    expect_store(st_base + word_t'(st_off), regs_m[rs], 4'hf);
    st_off += 4;
  endtask

  task automatic store_narrow(int f3, int off);  // sb or sh of x1
    word_t  data;
    wmask_t mask;
    put(s_type(word_t'(st_off + off), 1, 3, f3));
    if (f3 == 0) begin
      data = {4{regs_m[1][7:0]}};
      mask = wmask_t'(1 << off);
    end else begin
      data = {2{regs_m[1][15:0]}};
      mask = (off == 2) ? 4'b1100 : 4'b0011;
    end
    expect_store(st_base + word_t'(st_off + off), data, mask);
    st_off += 4;
  endtask

  task automatic load_check(int f3, int off);
    logic [7:0]  b;
    logic [15:0] h;
    b = rand_word[8*off +: 8];
    h = (off >= 2) ? rand_word[31:16] : rand_word[15:0];
    put(i_type(word_t'(off - 16), 6, f3, 7, `RV_OP_LOAD));  // x6 sits 16 bytes past the word
    case (f3)
      0:       regs_m[7] = {{24{b[7]}}, b};
      1:       regs_m[7] = {{16{h[15]}}, h};
      4:       regs_m[7] = {24'd0, b};
      5:       regs_m[7] = {16'd0, h};
      default: regs_m[7] = rand_word;
    endcase
    store_word(7);
  endtask

  task automatic reg_op(int f, logic alt);
    put(r_type(alt ? 7'h20 : 7'h00, 2, 1, f, 5));
    regs_m[5] = alu_ref(3'(f), alt, regs_m[1], regs_m[2]);
    store_word(5);
  endtask

  task automatic imm_op(int f, logic alt);
    word_t imm;
    word_t b;
    if (f == 1 || f == 5) begin
      imm = alt ? 32'h0000_040d : 32'h0000_000d;  // shamt 13, bit 10 picks srai
      b   = 32'd13;
    end else begin
      imm = 32'hffff_fedd;
      b   = imm;
    end
    put(i_type(imm, 1, f, 5, `RV_OP_OP_IMM));
    regs_m[5] = alu_ref(3'(f), alt, regs_m[1], b);
    store_word(5);
  endtask

  task automatic taken_branch(int f3, int rs1, int rs2);
    put(b_type(8, rs2, rs1, f3));
    put_skipped(s_type(0, 8, 3, 2));  // poison store, never reached
  endtask

  task automatic build_program();
    load_imm(1, 32'h8765_4321);
    load_imm(2, 32'h1234_5f07);
    load_imm(3, st_base);
    load_imm(6, rand_addr + 32'd16);  // loads use negative offsets
    load_imm(8, poison);
    regs_m[4] = cur_pc() + 32'h1234_5000;
    put(u_type(32'h12345, 4, `RV_OP_AUIPC));
    store_word(4);
    for (int f = 0; f < 8; f++) begin
      reg_op(f, 1'b0);
      if (f == 0 || f == 5) reg_op(f, 1'b1);  // sub, sra
    end
    for (int f = 0; f < 8; f++) begin
      imm_op(f, 1'b0);
      if (f == 5) imm_op(f, 1'b1);
    end
    for (int off = 0; off < 4; off++) store_narrow(0, off);
    store_narrow(1, 0);
    store_narrow(1, 2);
    for (int off = 0; off < 4; off++) begin
      load_check(0, off);
      load_check(4, off);
    end
    for (int off = 0; off < 4; off += 2) begin
      load_check(1, off);
      load_check(5, off);
    end
    load_check(2, 0);
    taken_branch(0, 1, 1);  // beq
    taken_branch(1, 1, 2);  // bne
    taken_branch(4, 1, 2);  // blt, x1 is negative
    taken_branch(5, 2, 1);  // bge
    taken_branch(6, 2, 1);  // bltu, x1 larger unsigned
    taken_branch(7, 1, 2);  // bgeu
    put(b_type(8, 2, 1, 0));  // beq x1, x2 falls through
    store_word(1);
    regs_m[9] = cur_pc() + 4;
    put(j_type(8, 9));
    put_skipped(s_type(0, 8, 3, 2));
    store_word(9);
    regs_m[10] = cur_pc();
    put(u_type(0, 10, `RV_OP_AUIPC));
    regs_m[11] = cur_pc() + 4;
    put(i_type(13, 10, 0, 11, `RV_OP_JALR));  // odd offset, target lands two words on
    put_skipped(s_type(0, 8, 3, 2));
    store_word(11);
    store_word(10);
    put(32'h0010_0073);  // ebreak
  endtask

  task automatic check_cycle();
    since_fetch++;
    if (imem_req) begin
      assert (!halted_seen) else abort_run("instruction fetch issued after halt");
      assert (exp_fetch.size() > 0) else abort_run("fetch beyond the end of the program");
      assert (imem_addr == exp_fetch[0])
        else abort_run($sformatf("MISMATCH at %0d ns: fetch addr %h, expected %h",
                                 $time, imem_addr, exp_fetch[0]));
      assert (!fetch_seen || since_fetch == 4)
        else abort_run($sformatf(
               "MISMATCH at %0d ns: fetch %0d cycles after the last, expected 4",
               $time, since_fetch));
      void'(exp_fetch.pop_front());
      fetch_seen  = 1'b1;
      since_fetch = 0;
    end
    if (dmem_we) begin
      assert (dmem_wdata != poison)
        else abort_run($sformatf(
               "MISMATCH at %0d ns: poison store at %h, branch or jump not taken",
               $time, dmem_addr));
      assert (exp_addr.size() > 0) else abort_run("store seen after the last expected one");
      assert (dmem_addr == exp_addr[0] && dmem_wdata == exp_data[0]
              && dmem_wmask == exp_mask[0])
        else abort_run($sformatf("MISMATCH at %0d ns: store %h %h mask %h, expected %h %h mask %h",
                                 $time, dmem_addr, dmem_wdata, dmem_wmask,
                                 exp_addr[0], exp_data[0], exp_mask[0]));
      for (int i = 0; i < 4; i++) begin
        if (dmem_wmask[i]) mem[mem_index(dmem_addr)][8*i +: 8] = dmem_wdata[8*i +: 8];
      end
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      void'(exp_mask.pop_front());
    end
    if (halted) begin
      halted_seen = 1'b1;
    end else begin
      assert (!halted_seen) else abort_run("halted dropped after it had risen");
    end
  endtask

  // mid-cycle sampling, requests answered on the next edge
  always @(negedge clk) begin
    imem_pend      = imem_req;
    imem_pend_addr = imem_addr;
    dmem_pend      = dmem_re;
    dmem_pend_addr = dmem_addr;
    if (!rst_n) begin
      assert (!imem_req && !dmem_re && !dmem_we && !halted)
        else abort_run($sformatf("MISMATCH at %0d ns: strobe or halted high in reset", $time));
    end else begin
      check_cycle();
    end
  end

  always @(posedge clk) begin
    #1;
    if (imem_pend) imem_rdata = mem[mem_index(imem_pend_addr)];
    if (dmem_pend) dmem_rdata = mem[mem_index(dmem_pend_addr)];
  end

  initial begin
    int limit;
    wait (prog_ready);
    limit = reset_cycles + 4 * exp_fetch.size() + 40;  // four cycles per instruction
    #(limit * clk_period);
    abort_run($sformatf("timeout: core did not halt within %0d cycles", limit));
  end

  initial begin
    rst_n      = 1'b0;
    imem_rdata = '0;
    dmem_rdata = '0;
    for (int i = 0; i < 512; i++) mem[i] = '0;
    for (int i = 0; i < 32; i++) regs_m[i] = '0;
    rand_word = $random(seed);
    mem[mem_index(rand_addr)] = rand_word;
    build_program();
    prog_ready = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 rst_n = 1'b1;
    wait (halted === 1'b1);
    repeat (8) @(posedge clk);  // room for a stray fetch to show
    if (exp_fetch.size() == 0 && exp_addr.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run($sformatf("halted with %0d fetches and %0d stores still outstanding",
                          exp_fetch.size(), exp_addr.size()));
    end
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
rv_pkg.sv
stage_ifs.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tb_rv_core
FILELIST    ?= tb.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
EXTRA_FLAGS ?=
PASS_TEXT   := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -f $(FILELIST) $(EXTRA_FLAGS)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
	  (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST) $(EXTRA_FLAGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
